/* source/cmul_defines.svh */
`ifndef CMUL_DEFINES_SVH
`define CMUL_DEFINES_SVH

// datapath widths
`define CMUL_DWIDTH      8           // operand element width, also the memory byte
`define CMUL_RWIDTH      18          // result element width
`define CMUL_AW          16          // system and memory address width
`define CMUL_REG_DW      16          // apb data and register width

// register file placement
`define CMUL_APB_BADDR   16'h0000    // base of the register window

// per-operation memory traffic
`define CMUL_OP_BYTES    4           // bytes read per operation
`define CMUL_RES_BYTES   6           // bytes written per operation
`define CMUL_OP_STRIDE   2           // operand address step
`define CMUL_RES_STRIDE  6           // result address step

`endif

/* source/cmul_arith_pkg.sv */
`default_nettype none

`include "cmul_defines.svh"

package cmul_arith_pkg;

    // one complex element as read from memory
    typedef struct packed {
        logic signed [`CMUL_DWIDTH-1:0] re;     // real part
        logic signed [`CMUL_DWIDTH-1:0] im;     // imaginary part
    } cplx_op_t;

    // both factors of one multiplication, 32 bits
    typedef struct packed {
        cplx_op_t a;                            // operand 1
        cplx_op_t b;                            // operand 2
    } operand_t;

    // product, 36 bits
    typedef struct packed {
        logic signed [`CMUL_RWIDTH-1:0] re;     // ar*br - ai*bi
        logic signed [`CMUL_RWIDTH-1:0] im;     // ar*bi + ai*br
    } result_t;

endpackage

`default_nettype wire

/* source/cmul_ctrl_pkg.sv */
`default_nettype none

`include "cmul_defines.svh"

package cmul_ctrl_pkg;

    // offsets from CMUL_APB_BADDR
    typedef enum logic [`CMUL_AW-1:0] {
        REG_OP1_ADDR = `CMUL_AW'(0),            // operand 1 base, rw
        REG_OP2_ADDR = `CMUL_AW'(1),            // operand 2 base, rw
        REG_RES_ADDR = `CMUL_AW'(2),            // result base, rw
        REG_NO_OP    = `CMUL_AW'(3),            // operation count, rw
        REG_START    = `CMUL_AW'(4),            // start bit, write only
        REG_DONE     = `CMUL_AW'(5),            // done bit, rw
        REG_STATE    = `CMUL_AW'(6)             // sequencer state, read only
    } reg_offset_e;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,                          // waiting for start
        RD_OPS = 2'd1,                          // fetching operand bytes
        WORK   = 2'd2,                          // waiting on the multiplier
        WR_RES = 2'd3                           // storing result bytes
    } seq_state_e;

    // software visible configuration, 64 bits
    typedef struct packed {
        logic [`CMUL_REG_DW-1:0] op1_addr;      // current operand 1 address
        logic [`CMUL_REG_DW-1:0] op2_addr;      // current operand 2 address
        logic [`CMUL_REG_DW-1:0] res_addr;      // current result address
        logic [`CMUL_REG_DW-1:0] no_op;         // operations per batch
    } cfg_t;

endpackage

`default_nettype wire

/* source/cmul_slice.sv */
`timescale 1ns/1ps
`default_nettype none

module cmul_slice #(
    parameter type payload_t = logic    // carried item
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    logic     full;     // entry occupied
    payload_t data_q;   // stored item

    // accept when empty or when the held item leaves this cycle
    assign in_ready  = ~full | out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            full <= 1'b0;
        else if (in_valid && in_ready)
            full <= 1'b1;
        else if (out_ready)
            full <= 1'b0;   // drained with nothing behind it
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) data_q <= in_data;
    end

endmodule

`default_nettype wire

/* source/cmul_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cmul_defines.svh"

module cmul_datapath (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      op_valid,
    input  cmul_arith_pkg::operand_t  op_data,
    output logic                      op_ready,
    output logic                      res_valid,
    output cmul_arith_pkg::result_t   res_data,
    input  logic                      res_ready
);
    import cmul_arith_pkg::*;

    localparam int PW  = 2 * `CMUL_DWIDTH;     // product width
    localparam int EXT = `CMUL_RWIDTH - PW;    // sign extension bits

    operand_t             ops;          // registered operands
    logic                 ops_valid;
    logic                 mid_ready;    // output slice can take a result
    result_t              prod;
    logic signed [PW-1:0] p_rr, p_ii, p_ri, p_ir;

    cmul_slice #(.payload_t(operand_t)) in_slice (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (op_valid),
        .in_data   (op_data),
        .in_ready  (op_ready),
        .out_valid (ops_valid),
        .out_data  (ops),
        .out_ready (mid_ready)      // stalls behind a held result
    );

    // four signed 8x8 products
    assign p_rr = ops.a.re * ops.b.re;
    assign p_ii = ops.a.im * ops.b.im;
    assign p_ri = ops.a.re * ops.b.im;
    assign p_ir = ops.a.im * ops.b.re;

    assign prod.re = {{EXT{p_rr[PW-1]}}, p_rr} - {{EXT{p_ii[PW-1]}}, p_ii};
    assign prod.im = {{EXT{p_ri[PW-1]}}, p_ri} + {{EXT{p_ir[PW-1]}}, p_ir};

    cmul_slice #(.payload_t(result_t)) out_slice (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (ops_valid),
        .in_data   (prod),
        .in_ready  (mid_ready),
        .out_valid (res_valid),
        .out_data  (res_data),
        .out_ready (res_ready)
    );

endmodule

`default_nettype wire

/* source/cmul_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cmul_defines.svh"

module cmul_apb_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`CMUL_AW-1:0]        paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`CMUL_REG_DW-1:0]    pwdata,
    input  cmul_ctrl_pkg::seq_state_e  state,
    input  logic                       finish,
    input  logic                       op_done,
    output logic [`CMUL_REG_DW-1:0]    prdata,
    output logic                       pready,
    output logic                       pslverr,
    output cmul_ctrl_pkg::cfg_t        cfg,
    output logic                       start
);
    import cmul_ctrl_pkg::*;

    localparam logic [`CMUL_REG_DW-1:0] OP_STEP  = `CMUL_REG_DW'(`CMUL_OP_STRIDE);
    localparam logic [`CMUL_REG_DW-1:0] RES_STEP = `CMUL_REG_DW'(`CMUL_RES_STRIDE);

    logic [`CMUL_AW-1:0]     offs;      // offset inside the register window
    logic                    setup;     // first apb cycle
    logic                    wr_sel;    // setup phase write
    logic                    rd_sel;    // setup phase read
    logic                    wr_ok;     // offset is writable
    logic                    rd_ok;     // offset is readable
    logic                    done;      // batch complete flag
    logic [`CMUL_REG_DW-1:0] rd_mux;    // read data before the register

    assign pready = 1'b1;               // no wait states
    assign offs   = paddr - `CMUL_APB_BADDR;
    assign setup  = psel & ~penable;
    assign wr_sel = setup & pwrite;
    assign rd_sel = setup & ~pwrite;

    // access rights per offset, anything else is unmapped
    always_comb begin
        wr_ok = 1'b0;
        rd_ok = 1'b0;
        case (offs)
            REG_OP1_ADDR, REG_OP2_ADDR, REG_RES_ADDR, REG_NO_OP, REG_DONE: begin
                wr_ok = 1'b1;
                rd_ok = 1'b1;
            end
            REG_START: wr_ok = 1'b1;                    // reads of start are errors
            REG_STATE: rd_ok = 1'b1;                    // state is read only
            default:   ;
        endcase
    end

    always_comb begin
        case (offs)
            REG_OP1_ADDR: rd_mux = cfg.op1_addr;
            REG_OP2_ADDR: rd_mux = cfg.op2_addr;
            REG_RES_ADDR: rd_mux = cfg.res_addr;
            REG_NO_OP:    rd_mux = cfg.no_op;
            REG_DONE:     rd_mux = {{(`CMUL_REG_DW-1){1'b0}}, done};
            REG_STATE:    rd_mux = {{(`CMUL_REG_DW-2){1'b0}}, state};  // zero extended
            default:      rd_mux = '0;
        endcase
    end

    // cpu write wins over the per-operation step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= '0;
        end else begin
            if (wr_sel && offs == REG_OP1_ADDR) cfg.op1_addr <= pwdata;
            else if (op_done)                   cfg.op1_addr <= cfg.op1_addr + OP_STEP;
            if (wr_sel && offs == REG_OP2_ADDR) cfg.op2_addr <= pwdata;
            else if (op_done)                   cfg.op2_addr <= cfg.op2_addr + OP_STEP;
            if (wr_sel && offs == REG_RES_ADDR) cfg.res_addr <= pwdata;
            else if (op_done)                   cfg.res_addr <= cfg.res_addr + RES_STEP;
            if (wr_sel && offs == REG_NO_OP)    cfg.no_op    <= pwdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start   <= 1'b0;
            done    <= 1'b0;
            pslverr <= 1'b0;
            prdata  <= '0;
        end else begin
            // single cycle pulse, only honoured while idle
            start   <= wr_sel && (offs == REG_START) && pwdata[0] && (state == IDLE);
            if (wr_sel && offs == REG_DONE) done <= pwdata[0];   // software clear
            else if (finish)                done <= 1'b1;
            pslverr <= setup && !(pwrite ? wr_ok : rd_ok);       // seen in access phase
            if (rd_sel) prdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

/* source/cmul_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cmul_defines.svh"

module cmul_sequencer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  cmul_ctrl_pkg::cfg_t        cfg,
    input  logic                       start,
    input  logic [`CMUL_DWIDTH-1:0]    mem_rd_data,
    input  logic                       op_ready,
    input  logic                       res_valid,
    input  cmul_arith_pkg::result_t    res_data,
    output cmul_ctrl_pkg::seq_state_e  state,
    output logic                       finish,
    output logic                       op_done,
    output logic                       mem_ce,
    output logic                       mem_we,
    output logic [`CMUL_AW-1:0]        mem_addr,
    output logic [`CMUL_DWIDTH-1:0]    mem_wr_data,
    output logic                       op_valid,
    output cmul_arith_pkg::operand_t   op_data,
    output logic                       res_ready
);
    import cmul_ctrl_pkg::*;

    localparam logic [2:0] RD_LAST = 3'(`CMUL_OP_BYTES - 1);    // index of op2 imaginary
    localparam logic [2:0] WR_LAST = 3'(`CMUL_RES_BYTES - 1);   // index of top imaginary byte
    localparam int         PAD     = 3 * `CMUL_DWIDTH - `CMUL_RWIDTH;

    logic [2:0]              byte_cnt;  // byte index within read or write burst
    logic [`CMUL_REG_DW-1:0] op_cnt;    // operations finished in this batch
    logic [`CMUL_REG_DW-1:0] op_cnt_nx;
    logic                    rd_last;   // last operand read issued
    logic                    wr_act;    // result byte write this cycle
    logic                    wr_last;   // sixth result byte
    logic                    wr_gap;    // turnaround before the next fetch
    logic                    last_op;   // current operation ends the batch
    logic                    rd_vld_q;  // read data arrives this cycle
    logic [1:0]              rd_idx_q;  // which operand byte it is

    assign op_cnt_nx = op_cnt + 1'b1;
    assign last_op   = (op_cnt_nx >= cfg.no_op);      // no_op of 0 still runs once
    assign rd_last   = (state == RD_OPS) && (byte_cnt == RD_LAST);
    assign wr_act    = (state == WR_RES) && (byte_cnt <= WR_LAST);
    assign wr_last   = (state == WR_RES) && (byte_cnt == WR_LAST);
    assign wr_gap    = (state == WR_RES) && (byte_cnt == WR_LAST + 3'd1);
    assign finish    = wr_last & last_op;
    assign op_done   = wr_last & ~last_op;
    assign res_ready = wr_last;                       // release the result with its last byte
    assign mem_ce    = (state == RD_OPS) | wr_act;
    assign mem_we    = wr_act;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            byte_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) state <= RD_OPS;
                    byte_cnt <= '0;
                end
                RD_OPS: begin
                    if (rd_last) begin
                        state    <= WORK;
                        byte_cnt <= '0;
                    end else begin
                        byte_cnt <= byte_cnt + 3'd1;
                    end
                end
                WORK: if (res_valid) state <= WR_RES;   // result waits in the output slice
                WR_RES: begin
                    if (finish) begin
                        state    <= IDLE;
                        byte_cnt <= '0;
                    end else if (wr_gap) begin
                        state    <= RD_OPS;             // stepped addresses now visible
                        byte_cnt <= '0;
                    end else begin
                        byte_cnt <= byte_cnt + 3'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_cnt   <= '0;
            rd_vld_q <= 1'b0;
            rd_idx_q <= '0;
            op_valid <= 1'b0;
        end else begin
            if (start)        op_cnt <= '0;
            else if (op_done) op_cnt <= op_cnt_nx;
            rd_vld_q <= (state == RD_OPS);              // one cycle read latency
            rd_idx_q <= byte_cnt[1:0];
            if (rd_vld_q && rd_idx_q == RD_LAST[1:0]) op_valid <= 1'b1;
            else if (op_ready)                        op_valid <= 1'b0;
        end
    end

    // operand bytes land as they come back, held until accepted
    always_ff @(posedge clk) begin
        if (rd_vld_q) begin
            case (rd_idx_q)
                2'd0: op_data.a.re <= mem_rd_data;
                2'd1: op_data.a.im <= mem_rd_data;
                2'd2: op_data.b.re <= mem_rd_data;
                2'd3: op_data.b.im <= mem_rd_data;
            endcase
        end
    end

    always_comb begin
        if (state == RD_OPS)    // op1 pair first, then op2 pair
            mem_addr = (byte_cnt[1] ? cfg.op2_addr : cfg.op1_addr)
                     + {{(`CMUL_AW-1){1'b0}}, byte_cnt[0]};
        else
            mem_addr = cfg.res_addr + {{(`CMUL_AW-3){1'b0}}, byte_cnt};
    end

    // little endian, top two bits of each part zero filled to a byte
    always_comb begin
        case (byte_cnt)
            3'd0:    mem_wr_data = res_data.re[`CMUL_DWIDTH-1:0];
            3'd1:    mem_wr_data = res_data.re[2*`CMUL_DWIDTH-1:`CMUL_DWIDTH];
            3'd2:    mem_wr_data = {{PAD{1'b0}}, res_data.re[`CMUL_RWIDTH-1:2*`CMUL_DWIDTH]};
            3'd3:    mem_wr_data = res_data.im[`CMUL_DWIDTH-1:0];
            3'd4:    mem_wr_data = res_data.im[2*`CMUL_DWIDTH-1:`CMUL_DWIDTH];
            default: mem_wr_data = {{PAD{1'b0}}, res_data.im[`CMUL_RWIDTH-1:2*`CMUL_DWIDTH]};
        endcase
    end

endmodule

`default_nettype wire

/* source/cmul_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cmul_defines.svh"

module cmul_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`CMUL_AW-1:0]      paddr,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [`CMUL_REG_DW-1:0]  pwdata,
    output logic [`CMUL_REG_DW-1:0]  prdata,
    output logic                     pready,
    output logic                     pslverr,
    output logic                     mem_ce,
    output logic                     mem_we,
    output logic [`CMUL_AW-1:0]      mem_addr,
    output logic [`CMUL_DWIDTH-1:0]  mem_wr_data,
    input  logic [`CMUL_DWIDTH-1:0]  mem_rd_data
);
    import cmul_ctrl_pkg::*;
    import cmul_arith_pkg::*;

    cfg_t       cfg;                    // live register values
    seq_state_e state;
    logic       start, finish, op_done;
    logic       op_valid, op_ready, res_valid, res_ready;
    operand_t   op_data;
    result_t    res_data;

    cmul_apb_regs regs_inst (
        .clk (clk), .rst_n (rst_n),
        .paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
        .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
        .state (state), .finish (finish), .op_done (op_done),
        .cfg (cfg), .start (start)
    );

    cmul_sequencer seq_inst (
        .clk (clk), .rst_n (rst_n), .cfg (cfg), .start (start),
        .state (state), .finish (finish), .op_done (op_done),
        .mem_ce (mem_ce), .mem_we (mem_we), .mem_addr (mem_addr),
        .mem_wr_data (mem_wr_data), .mem_rd_data (mem_rd_data),
        .op_valid (op_valid), .op_ready (op_ready), .op_data (op_data),
        .res_valid (res_valid), .res_ready (res_ready), .res_data (res_data)
    );

    cmul_datapath dp_inst (
        .clk (clk), .rst_n (rst_n),
        .op_valid (op_valid), .op_data (op_data), .op_ready (op_ready),
        .res_valid (res_valid), .res_data (res_data), .res_ready (res_ready)
    );

endmodule

`default_nettype wire

/* bench/cmul_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module cmul_clk_gen (
    output logic clk
);

    localparam realtime HALF = 50ns;    // 100 ns period

    initial clk = 1'b0;

    always #(HALF) clk = ~clk;

endmodule

`default_nettype wire

/* bench/cmul_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cmul_defines.svh"

module cmul_mem_model (
    input  logic                    clk,
    input  logic                    ce,
    input  logic                    we,
    input  logic [`CMUL_AW-1:0]     addr,
    input  logic [`CMUL_DWIDTH-1:0] wr_data,
    output logic [`CMUL_DWIDTH-1:0] rd_data
);

    logic [`CMUL_DWIDTH-1:0] mem [0:(1<<`CMUL_AW)-1];  // whole address space

    // background pattern mixes both address bytes
    initial begin
        for (int i = 0; i < (1 << `CMUL_AW); i++)
            mem[i] = i[7:0] ^ i[15:8] ^ 8'h3c;
        rd_data = '0;
    end

    // one cycle read latency, never stalls
    always @(posedge clk) begin
        if (ce) begin
            if (we) mem[addr] <= wr_data;
            else    rd_data   <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* bench/cmul_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cmul_defines.svh"

module cmul_tb;
    import cmul_ctrl_pkg::*;

    localparam int MAX_CYCLES = 3000;   // eight ops at ~20 cycles plus apb traffic, wide margin
    localparam int BATCH_N    = 5;

    logic                    clk, rst_n;
    logic [`CMUL_AW-1:0]     paddr;
    logic                    psel, penable, pwrite, pready, pslverr;
    logic [`CMUL_REG_DW-1:0] pwdata, prdata;
    logic                    mem_ce, mem_we;
    logic [`CMUL_AW-1:0]     mem_addr;
    logic [`CMUL_DWIDTH-1:0] mem_wr_data, mem_rd_data;

    int    cycles = 0;
    int    errors = 0;
    int    checks = 0;
    bit    cmp_busy = 1'b0;             // set while the compare process walks a region
    string cmp_name;
    logic [15:0] cmp_op1, cmp_op2, cmp_res;
    int    cmp_n;
    logic [7:0]  cmp_guard [0:1];       // bytes just past the result region

    cmul_clk_gen clk_gen_inst (.clk (clk));

    cmul_mem_model mem_inst (
        .clk (clk), .ce (mem_ce), .we (mem_we), .addr (mem_addr),
        .wr_data (mem_wr_data), .rd_data (mem_rd_data)
    );

    cmul_top cmul_top_inst (
        .clk (clk), .rst_n (rst_n),
        .paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
        .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
        .mem_ce (mem_ce), .mem_we (mem_we), .mem_addr (mem_addr),
        .mem_wr_data (mem_wr_data), .mem_rd_data (mem_rd_data)
    );

    // expected six bytes, byte 0 in bits 7:0
    function automatic logic [47:0] cmul_ref(input logic signed [7:0] ar, ai, br, bi);
        int          re, im;
        logic [17:0] r, i;
        re = ar * br - ai * bi;
        im = ar * bi + ai * br;
        r  = re[17:0];
        i  = im[17:0];
        return {6'b0, i[17:16], i[15:8], i[7:0], 6'b0, r[17:16], r[15:8], r[7:0]};
    endfunction

    task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp, act);
        end
    endtask

    task automatic apb_write(input logic [15:0] addr, input logic [15:0] data, output logic err);
        @(posedge clk); #1;
        psel = 1'b1; penable = 1'b0; pwrite = 1'b1; paddr = addr; pwdata = data;  // setup
        @(posedge clk); #1;
        penable = 1'b1;                                   // access
        @(negedge clk);
        err = pslverr;
        check_eq($sformatf("pready write 0x%0h", addr), 1, pready);     // no wait states
        @(posedge clk); #1;
        psel = 1'b0; penable = 1'b0; pwrite = 1'b0;
    endtask

    task automatic apb_read(input logic [15:0] addr, output logic [15:0] data, output logic err);
        @(posedge clk); #1;
        psel = 1'b1; penable = 1'b0; pwrite = 1'b0; paddr = addr;
        @(posedge clk); #1;
        penable = 1'b1;
        @(negedge clk);                                   // registered data valid here
        data = prdata;
        err  = pslverr;
        check_eq($sformatf("pready read 0x%0h", addr), 1, pready);
        @(posedge clk); #1;
        psel = 1'b0; penable = 1'b0;
    endtask

    task automatic load_pair(input logic [15:0] addr, input logic [7:0] re, input logic [7:0] im);
        mem_inst.mem[addr]     = re;
        mem_inst.mem[addr + 1] = im;
    endtask

    task automatic program_regs(input logic [15:0] op1, op2, res, n);
        logic err;
        apb_write(REG_OP1_ADDR, op1, err);
        apb_write(REG_OP2_ADDR, op2, err);
        apb_write(REG_RES_ADDR, res, err);
        apb_write(REG_NO_OP, n, err);
        apb_write(REG_DONE, 16'h0, err);                  // clear a stale done
    endtask

    task automatic snapshot_guard(input logic [15:0] res, input int n);
        for (int i = 0; i < 2; i++)
            cmp_guard[i] = mem_inst.mem[16'(res + `CMUL_RES_STRIDE * n + i)];
    endtask

    task automatic start_and_wait();
        logic        err;
        logic [15:0] d;
        apb_write(REG_START, 16'h1, err);
        d = '0;
        while (d[0] !== 1'b1) apb_read(REG_DONE, d, err);  // global cycle limit bounds this
    endtask

    task automatic request_compare(input string name, input logic [15:0] op1, op2, res,
                                   input int n);
        cmp_name = name;
        cmp_op1  = op1;
        cmp_op2  = op2;
        cmp_res  = res;
        cmp_n    = n;
        cmp_busy = 1'b1;
        wait (!cmp_busy);
    endtask

    task automatic report_test(input string name, input int e0);
        $display("test %-16s finished with %0d errors", name, errors - e0);
    endtask

    // walks the result region once done is set
    initial begin : compare_proc
        logic [47:0] exp, act;
        logic [15:0] a1, a2, ar;
        forever begin
            wait (cmp_busy);
            for (int k = 0; k < cmp_n; k++) begin
                a1  = cmp_op1 + `CMUL_OP_STRIDE * k;
                a2  = cmp_op2 + `CMUL_OP_STRIDE * k;
                ar  = cmp_res + `CMUL_RES_STRIDE * k;
                exp = cmul_ref(mem_inst.mem[a1], mem_inst.mem[a1 + 1],
                               mem_inst.mem[a2], mem_inst.mem[a2 + 1]);
                act = {mem_inst.mem[ar + 5], mem_inst.mem[ar + 4], mem_inst.mem[ar + 3],
                       mem_inst.mem[ar + 2], mem_inst.mem[ar + 1], mem_inst.mem[ar]};
                check_eq($sformatf("%s op %0d", cmp_name, k), exp, act);
            end
            ar = cmp_res + `CMUL_RES_STRIDE * cmp_n;
            for (int i = 0; i < 2; i++)
                check_eq($sformatf("%s guard %0d", cmp_name, i), cmp_guard[i],
                         mem_inst.mem[ar + i]);
            cmp_busy = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run timed out after %0d cycles, the DUT never finished", cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin : main_proc
        logic [15:0] d, vals [0:3];
        logic        err;
        int          e0;
        void'($urandom(96262));
        rst_n = 1'b0; psel = 1'b0; penable = 1'b0; pwrite = 1'b0;
        paddr = '0; pwdata = '0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;

        e0 = errors;
        apb_read(REG_STATE, d, err);
        check_eq("reset state", 0, d);
        apb_read(REG_DONE, d, err);
        check_eq("reset done", 0, d);
        for (int i = 0; i < 4; i++) begin
            vals[i] = 16'($urandom);
            apb_write(16'(i), vals[i], err);
        end
        for (int i = 0; i < 4; i++) begin
            apb_read(16'(i), d, err);
            check_eq($sformatf("readback %0d", i), vals[i], d);
        end
        report_test("reset_readback", e0);

        e0 = errors;
        apb_read(REG_START, d, err);
        check_eq("read start slverr", 1, err);
        apb_write(16'd9, 16'h0, err);
        check_eq("write 9 slverr", 1, err);
        apb_read(16'd9, d, err);
        check_eq("read 9 slverr", 1, err);
        apb_read(REG_OP1_ADDR, d, err);
        check_eq("read 0 slverr", 0, err);
        apb_write(REG_NO_OP, 16'd1, err);
        check_eq("write 3 slverr", 0, err);
        report_test("slave_error", e0);

        e0 = errors;
        load_pair(16'h0100, 8'sd127, -8'sd128);           // corner of the signed range
        load_pair(16'h0200, -8'sd128, 8'sd127);
        program_regs(16'h0100, 16'h0200, 16'h0300, 16'd1);
        snapshot_guard(16'h0300, 1);
        start_and_wait();
        request_compare("single_a", 16'h0100, 16'h0200, 16'h0300, 1);
        apb_read(REG_DONE, d, err);
        check_eq("single_a done", 1, d);
        load_pair(16'h0110, 8'sd3, -8'sd4);
        load_pair(16'h0210, 8'sd5, 8'sd6);
        program_regs(16'h0110, 16'h0210, 16'h0310, 16'd1);
        snapshot_guard(16'h0310, 1);
        start_and_wait();
        request_compare("single_b", 16'h0110, 16'h0210, 16'h0310, 1);
        apb_read(REG_DONE, d, err);
        check_eq("single_b done", 1, d);
        report_test("single_op", e0);

        e0 = errors;
        for (int k = 0; k < BATCH_N; k++) begin
            load_pair(16'h0400 + 2 * k, 8'($urandom), 8'($urandom));
            load_pair(16'h0500 + 2 * k, 8'($urandom), 8'($urandom));
        end
        program_regs(16'h0400, 16'h0500, 16'h0600, 16'(BATCH_N));
        snapshot_guard(16'h0600, BATCH_N);
        start_and_wait();
        request_compare("batch", 16'h0400, 16'h0500, 16'h0600, BATCH_N);
        report_test("batch", e0);

        e0 = errors;
        apb_write(REG_DONE, 16'h0, err);
        apb_read(REG_DONE, d, err);
        check_eq("done cleared", 0, d);
        apb_read(REG_STATE, d, err);
        check_eq("state idle", 0, d);
        // op_done steps the addresses for every op except the last
        apb_read(REG_OP1_ADDR, d, err);
        check_eq("stepped op1", 16'h0400 + `CMUL_OP_STRIDE * (BATCH_N - 1), d);
        apb_read(REG_OP2_ADDR, d, err);
        check_eq("stepped op2", 16'h0500 + `CMUL_OP_STRIDE * (BATCH_N - 1), d);
        apb_read(REG_RES_ADDR, d, err);
        check_eq("stepped res", 16'h0600 + `CMUL_RES_STRIDE * (BATCH_N - 1), d);
        load_pair(16'h0408, 8'($urandom), 8'($urandom));   // fresh data at the stepped pair
        load_pair(16'h0508, 8'($urandom), 8'($urandom));
        apb_write(REG_NO_OP, 16'd1, err);
        snapshot_guard(16'h0618, 1);
        start_and_wait();
        request_compare("rerun", 16'h0408, 16'h0508, 16'h0618, 1);
        apb_read(REG_STATE, d, err);
        check_eq("state after rerun", 0, d);
        report_test("done_clear_state", e0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+source
source/cmul_arith_pkg.sv
source/cmul_ctrl_pkg.sv
source/cmul_slice.sv
source/cmul_datapath.sv
source/cmul_apb_regs.sv
source/cmul_sequencer.sv
source/cmul_top.sv
bench/cmul_clk_gen.sv
bench/cmul_mem_model.sv
bench/cmul_tb.sv

/* Bender.yml */
package:
  name: cmul

sources:
  - include_dirs:
      - source
    files:
      - source/cmul_arith_pkg.sv
      - source/cmul_ctrl_pkg.sv
      - source/cmul_slice.sv
      - source/cmul_datapath.sv
      - source/cmul_apb_regs.sv
      - source/cmul_sequencer.sv
      - source/cmul_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/cmul_clk_gen.sv
      - bench/cmul_mem_model.sv
      - bench/cmul_tb.sv
